//--- logic/shade_pkg.sv
package shade_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    localparam int COORD_WIDTH   = 24;
    localparam int DIR_WIDTH     = 16;
    localparam int DIST_WIDTH    = 16;
    localparam int CHANNEL_WIDTH = 8;

    // sums and differences carry one extra bit
    localparam int WIDE_WIDTH = COORD_WIDTH + 1;

    // signed direction times zero-extended distance
    localparam int PROD_WIDTH = DIR_WIDTH + DIST_WIDTH + 1;

    // fraction bits of a ray direction component
    localparam int DIR_FRAC_BITS = 14;

    ////////////////////////////////////////////////////////////
    // types

    typedef logic signed [COORD_WIDTH-1:0] coord_t;
    typedef logic signed [DIR_WIDTH-1:0]   dir_t;
    typedef logic        [DIST_WIDTH-1:0]  dist_t;
    typedef logic        [CHANNEL_WIDTH-1:0] channel_t;
    typedef logic signed [WIDE_WIDTH-1:0]  wide_t;
    typedef logic signed [PROD_WIDTH-1:0]  prod_t;

    typedef enum logic {
        BLUE,
        RED
    } block_color_e;

    // arrow painted on the top face
    typedef enum logic [1:0] {
        UP,
        RIGHT,
        DOWN,
        LEFT
    } arrow_dir_e;

    ////////////////////////////////////////////////////////////
    // geometry and colour constants

    localparam coord_t   BLOCK_SPAN       = 24'sd200;
    localparam coord_t   ARROW_HALF_WIDTH = 24'sd80;
    localparam channel_t CHANNEL_FULL     = 8'd255;

    // stage latencies in cycles
    localparam int SCALE_LATENCY = 2;
    localparam int ARROW_LATENCY = 3;
    localparam int OUT_LATENCY   = 1;
    localparam int TOTAL_LATENCY = SCALE_LATENCY + ARROW_LATENCY + OUT_LATENCY;

endpackage

//--- logic/delay_line.sv
`timescale 1ns/100ps

module delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    // stage 0 takes the input, last stage drives the output
    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_out = stage_q[DEPTH-1];

endmodule

//--- logic/ray_scale.sv
`timescale 1ns/100ps

module ray_scale import shade_pkg::*; (
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   valid_in,
    input  dir_t   ray_x,
    input  dir_t   ray_y,
    input  dir_t   ray_z,
    input  dist_t  t_in,
    input  coord_t eye_x,
    input  coord_t eye_y,
    input  coord_t eye_z,
    input  coord_t block_x,
    input  coord_t block_y,
    input  coord_t block_z,
    output coord_t rel_x,
    output coord_t rel_y,
    output coord_t rel_z,
    output coord_t blk_x,
    output coord_t blk_y,
    output coord_t blk_z,
    output logic   scaled_valid
);

    logic [SCALE_LATENCY-1:0] valid_q;

    prod_t prod_x, prod_y, prod_z;
    wide_t diff_x, diff_y, diff_z;
    prod_t shift_x, shift_y, shift_z;

    ////////////////////////////////////////////////////////////
    // stage one: full products and eye-relative block position

    always_ff @(posedge clk_in) begin
        prod_x <= ray_x * $signed({1'b0, t_in});
        prod_y <= ray_y * $signed({1'b0, t_in});
        prod_z <= ray_z * $signed({1'b0, t_in});
        diff_x <= block_x - eye_x;
        diff_y <= block_y - eye_y;
        diff_z <= block_z - eye_z;
    end

    ////////////////////////////////////////////////////////////
    // stage two: drop the direction fraction

    // arithmetic shift floors toward minus infinity
    assign shift_x = prod_x >>> DIR_FRAC_BITS;
    assign shift_y = prod_y >>> DIR_FRAC_BITS;
    assign shift_z = prod_z >>> DIR_FRAC_BITS;

    always_ff @(posedge clk_in) begin
        rel_x <= shift_x[COORD_WIDTH-1:0];
        rel_y <= shift_y[COORD_WIDTH-1:0];
        rel_z <= shift_z[COORD_WIDTH-1:0];
        blk_x <= diff_x[COORD_WIDTH-1:0];
        blk_y <= diff_y[COORD_WIDTH-1:0];
        blk_z <= diff_z[COORD_WIDTH-1:0];
    end

    // strobe walks alongside the data
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[SCALE_LATENCY-2:0], valid_in};
        end
    end

    assign scaled_valid = valid_q[SCALE_LATENCY-1];

endmodule

//--- logic/arrow_test.sv
`timescale 1ns/100ps

module arrow_test import shade_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       valid_in,
    input  coord_t     rel_x,
    input  coord_t     rel_y,
    input  coord_t     rel_z,
    input  coord_t     blk_x,
    input  coord_t     blk_y,
    input  coord_t     blk_z,
    input  arrow_dir_e block_dir,
    output logic       arrow_hit,
    output logic       arrow_valid
);

    logic [ARROW_LATENCY-1:0] valid_q;

    // top of the block face for the depth test
    wide_t span_top;

    // stage one results
    wide_t      sum_hit, sum_blk;
    wide_t      dif_hit, dif_blk;
    wide_t      x_lo, x_hi;
    wide_t      y_lo, y_hi;
    coord_t     hit_x_s1, hit_y_s1;
    coord_t     blk_x_s1, blk_y_s1;
    logic       depth_s1;
    arrow_dir_e dir_s1;

    // stage two results
    logic       region_a, region_c;
    logic       in_bounds;
    logic       x_lt, y_lt;
    logic       depth_s2;
    arrow_dir_e dir_s2;

    ////////////////////////////////////////////////////////////
    // stage one: diagonals, bounds edges, depth flag

    assign span_top = blk_z + BLOCK_SPAN;

    always_ff @(posedge clk_in) begin
        sum_hit  <= rel_y + rel_x;
        sum_blk  <= blk_y + blk_x;
        dif_hit  <= rel_y - rel_x;
        dif_blk  <= blk_y - blk_x;
        x_lo     <= blk_x - ARROW_HALF_WIDTH;
        x_hi     <= blk_x + ARROW_HALF_WIDTH;
        y_lo     <= blk_y - ARROW_HALF_WIDTH;
        y_hi     <= blk_y + ARROW_HALF_WIDTH;
        hit_x_s1 <= rel_x;
        hit_y_s1 <= rel_y;
        blk_x_s1 <= blk_x;
        blk_y_s1 <= blk_y;
        depth_s1 <= (rel_z <= span_top);
        dir_s1   <= block_dir;
    end

    ////////////////////////////////////////////////////////////
    // stage two: comparisons

    always_ff @(posedge clk_in) begin
        // diagonals split the face into four triangles
        region_a  <= (sum_hit < sum_blk);
        region_c  <= (dif_hit < dif_blk);
        in_bounds <= (x_lo < hit_x_s1) && (hit_x_s1 < x_hi) &&
                     (y_lo < hit_y_s1) && (hit_y_s1 < y_hi);
        x_lt      <= (hit_x_s1 < blk_x_s1);
        y_lt      <= (hit_y_s1 < blk_y_s1);
        depth_s2  <= depth_s1;
        dir_s2    <= dir_s1;
    end

    ////////////////////////////////////////////////////////////
    // stage three: direction decision

    always_ff @(posedge clk_in) begin
        if (!(depth_s2 && in_bounds)) begin
            arrow_hit <= 1'b0;
        end else begin
            case (dir_s2)
                DOWN: begin
                    arrow_hit <= y_lt && region_a && region_c;
                end
                LEFT: begin
                    arrow_hit <= !x_lt && !region_a && region_c;
                end
                UP: begin
                    arrow_hit <= !y_lt && !region_a && !region_c;
                end
                default: begin
                    // right-pointing arrow
                    arrow_hit <= x_lt && region_a && !region_c;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[ARROW_LATENCY-2:0], valid_in};
        end
    end

    assign arrow_valid = valid_q[ARROW_LATENCY-1];

endmodule

//--- logic/pixel_color_out.sv
`timescale 1ns/100ps

module pixel_color_out import shade_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         valid_in,
    input  logic         arrow_hit,
    input  block_color_e block_color,
    output channel_t     r_out,
    output channel_t     g_out,
    output channel_t     b_out,
    output logic         rgb_valid
);

    ////////////////////////////////////////////////////////////
    // material decode, arrow overrides to white

    // outputs only move on a valid pixel
    always_ff @(posedge clk_in) begin
        if (valid_in) begin
            if (arrow_hit) begin
                r_out <= CHANNEL_FULL;
                g_out <= CHANNEL_FULL;
                b_out <= CHANNEL_FULL;
            end else if (block_color == RED) begin
                r_out <= CHANNEL_FULL;
                g_out <= '0;
                b_out <= '0;
            end else begin
                r_out <= '0;
                g_out <= '0;
                b_out <= CHANNEL_FULL;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= valid_in;
        end
    end

endmodule

//--- logic/pixel_shade_top.sv
`timescale 1ns/100ps

module pixel_shade_top import shade_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         valid_in,
    input  dir_t         ray_x,
    input  dir_t         ray_y,
    input  dir_t         ray_z,
    input  dist_t        t_in,
    input  coord_t       eye_x,
    input  coord_t       eye_y,
    input  coord_t       eye_z,
    input  coord_t       block_x,
    input  coord_t       block_y,
    input  coord_t       block_z,
    input  arrow_dir_e   block_dir,
    input  block_color_e block_color,
    output channel_t     r_out,
    output channel_t     g_out,
    output channel_t     b_out,
    output logic         rgb_valid
);

    coord_t rel_x, rel_y, rel_z;
    coord_t blk_x, blk_y, blk_z;
    logic   scaled_valid;
    logic   arrow_hit;
    logic   arrow_valid;

    // side data delayed to meet its stage
    logic [$bits(arrow_dir_e)-1:0]   dir_dly;
    logic [$bits(block_color_e)-1:0] color_dly;

    ////////////////////////////////////////////////////////////
    // scale stage

    ray_scale ray_scale_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .valid_in     (valid_in),
        .ray_x        (ray_x),
        .ray_y        (ray_y),
        .ray_z        (ray_z),
        .t_in         (t_in),
        .eye_x        (eye_x),
        .eye_y        (eye_y),
        .eye_z        (eye_z),
        .block_x      (block_x),
        .block_y      (block_y),
        .block_z      (block_z),
        .rel_x        (rel_x),
        .rel_y        (rel_y),
        .rel_z        (rel_z),
        .blk_x        (blk_x),
        .blk_y        (blk_y),
        .blk_z        (blk_z),
        .scaled_valid (scaled_valid)
    );

    delay_line #(
        .WIDTH ($bits(arrow_dir_e)),
        .DEPTH (SCALE_LATENCY)
    ) dir_delay_i (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_in  (block_dir),
        .data_out (dir_dly)
    );

    ////////////////////////////////////////////////////////////
    // arrow test and colour output

    arrow_test arrow_test_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (scaled_valid),
        .rel_x       (rel_x),
        .rel_y       (rel_y),
        .rel_z       (rel_z),
        .blk_x       (blk_x),
        .blk_y       (blk_y),
        .blk_z       (blk_z),
        .block_dir   (arrow_dir_e'(dir_dly)),
        .arrow_hit   (arrow_hit),
        .arrow_valid (arrow_valid)
    );

    // colour waits out both the scale and arrow stages
    delay_line #(
        .WIDTH ($bits(block_color_e)),
        .DEPTH (SCALE_LATENCY + ARROW_LATENCY)
    ) color_delay_i (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_in  (block_color),
        .data_out (color_dly)
    );

    pixel_color_out pixel_color_out_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (arrow_valid),
        .arrow_hit   (arrow_hit),
        .block_color (block_color_e'(color_dly)),
        .r_out       (r_out),
        .g_out       (g_out),
        .b_out       (b_out),
        .rgb_valid   (rgb_valid)
    );

endmodule

//--- verification/pixel_shade_chk.sv
`timescale 1ns/100ps

module pixel_shade_chk import shade_pkg::*; (
    input logic clk_in,
    input logic rst_in,
    input logic valid_in,
    input logic rgb_valid
);

    ////////////////////////////////////////////////////////////
    // reset state

    reset_clears_valid: assert property (
        @(posedge clk_in) $past(rst_in) |-> !rgb_valid
    ) else $error("rgb_valid high in the cycle after reset");

    ////////////////////////////////////////////////////////////
    // one output strobe per input strobe

    fixed_latency: assert property (
        @(posedge clk_in) disable iff (rst_in)
        rgb_valid == $past(valid_in, TOTAL_LATENCY)
    ) else $error("rgb_valid does not follow valid_in by the pipeline latency");

endmodule

//--- verification/pixel_shade_tb.sv
`timescale 1ns/100ps

module pixel_shade_tb import shade_pkg::*;;

    logic         clk_in;
    logic         rst_in;
    logic         valid_in;
    dir_t         ray_x, ray_y, ray_z;
    dist_t        t_in;
    coord_t       eye_x, eye_y, eye_z;
    coord_t       block_x, block_y, block_z;
    arrow_dir_e   block_dir;
    block_color_e block_color;
    channel_t     r_out, g_out, b_out;
    logic         rgb_valid;

    int          seed = 32'hce5f;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err0;
    string       test_name;
    int          cycle_cnt = 0;
    int          pixels_in = 0;
    int          pixels_out = 0;
    logic [23:0] exp_q[$];
    int          stamp_q[$];
    logic [23:0] want;
    int          stamp;

    pixel_shade_top pixel_shade_top_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid_in    (valid_in),
        .ray_x       (ray_x),
        .ray_y       (ray_y),
        .ray_z       (ray_z),
        .t_in        (t_in),
        .eye_x       (eye_x),
        .eye_y       (eye_y),
        .eye_z       (eye_z),
        .block_x     (block_x),
        .block_y     (block_y),
        .block_z     (block_z),
        .block_dir   (block_dir),
        .block_color (block_color),
        .r_out       (r_out),
        .g_out       (g_out),
        .b_out       (b_out),
        .rgb_valid   (rgb_valid)
    );

    bind pixel_shade_top pixel_shade_chk pixel_shade_chk_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .rgb_valid (rgb_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    ////////////////////////////////////////////////////////////
    // reference model over the inputs the DUT samples

    function automatic logic [23:0] model_rgb();
        longint hx, hy, hz;
        longint bx, by, bz;
        longint half;
        bit     depth_ok, in_box, reg_a, reg_c, x_below, y_below, arrow;
        half = longint'(ARROW_HALF_WIDTH);
        hx = (longint'(ray_x) * longint'(t_in)) >>> DIR_FRAC_BITS;
        hy = (longint'(ray_y) * longint'(t_in)) >>> DIR_FRAC_BITS;
        hz = (longint'(ray_z) * longint'(t_in)) >>> DIR_FRAC_BITS;
        bx = longint'(block_x) - longint'(eye_x);
        by = longint'(block_y) - longint'(eye_y);
        bz = longint'(block_z) - longint'(eye_z);
        depth_ok = (hz <= bz + longint'(BLOCK_SPAN));
        in_box = (bx - half < hx) && (hx < bx + half) &&
                 (by - half < hy) && (hy < by + half);
        reg_a = (hy + hx) < (by + bx);
        reg_c = (hy - hx) < (by - bx);
        x_below = hx < bx;
        y_below = hy < by;
        arrow = 1'b0;
        case (block_dir)
            UP:    arrow = !y_below && !reg_a && !reg_c;
            RIGHT: arrow = x_below && reg_a && !reg_c;
            DOWN:  arrow = y_below && reg_a && reg_c;
            LEFT:  arrow = !x_below && !reg_a && reg_c;
        endcase
        if (arrow && depth_ok && in_box) begin
            return {CHANNEL_FULL, CHANNEL_FULL, CHANNEL_FULL};
        end
        if (block_color == RED) begin
            return {CHANNEL_FULL, 8'd0, 8'd0};
        end
        return {8'd0, 8'd0, CHANNEL_FULL};
    endfunction

    function automatic int rand_range(int lo, int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'({$random(seed)} % span);
    endfunction

    task automatic check_value(string name, int expected, int actual);
        checks++;
        assert (expected == actual) else begin
            $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard

    // expected colour captured where the DUT samples its strobe
    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst_in && valid_in) begin
            exp_q.push_back(model_rgb());
            stamp_q.push_back(cycle_cnt);
            pixels_in++;
        end
    end

    always @(negedge clk_in) begin
        if (!rst_in && rgb_valid) begin
            pixels_out++;
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("rgb_valid at %0t with no pixel in flight", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want  = exp_q.pop_front();
                stamp = stamp_q.pop_front();
                check_value("r_out", int'(want[23:16]), int'(r_out));
                check_value("g_out", int'(want[15:8]), int'(g_out));
                check_value("b_out", int'(want[7:0]), int'(b_out));
                check_value("rgb_valid latency", TOTAL_LATENCY, cycle_cnt - stamp);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    task automatic send_pixel(int rx, int ry, int rz, int t, int ex, int ey, int ez,
                              int bx, int by, int bz, arrow_dir_e d, block_color_e c);
        @(negedge clk_in);
        ray_x       = dir_t'(rx);
        ray_y       = dir_t'(ry);
        ray_z       = dir_t'(rz);
        t_in        = dist_t'(t);
        eye_x       = coord_t'(ex);
        eye_y       = coord_t'(ey);
        eye_z       = coord_t'(ez);
        block_x     = coord_t'(bx);
        block_y     = coord_t'(by);
        block_z     = coord_t'(bz);
        block_dir   = d;
        block_color = c;
        valid_in    = 1'b1;
    endtask

    // offsets from the block centre
    // block sits at (1000, 1000, 250) from the eye
    // t of 4096 makes the hit equal to the direction over 4
    task automatic send_hit(int dx, int dy, int dz, arrow_dir_e d, block_color_e c);
        send_pixel(4 * (1000 + dx), 4 * (1000 + dy), 4 * (250 + dz), 4096,
                   100, -200, 50, 1100, 800, 300, d, c);
    endtask

    task automatic send_random();
        int ex, ey, ez, bx, by, bz, rx, ry, rz, t;
        arrow_dir_e   d;
        block_color_e c;
        d = arrow_dir_e'(rand_range(0, 3));
        c = block_color_e'(rand_range(0, 1));
        ex = rand_range(-2000, 2000);
        ey = rand_range(-2000, 2000);
        ez = rand_range(-2000, 2000);
        if (rand_range(0, 1) == 1) begin
            // aim close to the block so arrows show up often
            bx = ex + rand_range(-2000, 2000);
            by = ey + rand_range(-2000, 2000);
            bz = ez + rand_range(-2000, 2000);
            rx = 4 * (bx - ex + rand_range(-100, 100)) + rand_range(0, 3);
            ry = 4 * (by - ey + rand_range(-100, 100)) + rand_range(0, 3);
            rz = 4 * (bz - ez + rand_range(-100, 300)) + rand_range(0, 3);
            t = 4096;
        end else begin
            ex = rand_range(-4096, 4096);
            ey = rand_range(-4096, 4096);
            ez = rand_range(-4096, 4096);
            bx = rand_range(-4096, 4096);
            by = rand_range(-4096, 4096);
            bz = rand_range(-4096, 4096);
            rx = rand_range(-32768, 32767);
            ry = rand_range(-32768, 32767);
            rz = rand_range(-32768, 32767);
            t = rand_range(0, 65535);
        end
        send_pixel(rx, ry, rz, t, ex, ey, ez, bx, by, bz, d, c);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk_in);
            valid_in = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        idle(1);
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 40) begin
            @(posedge clk_in);
            cycles++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timeout at %0t: %0d pixels never came out", $time, exp_q.size());
            errors++;
            exp_q.delete();
            stamp_q.delete();
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic finish_test();
        wait_drain();
        // quiet cycles so a stray strobe is still caught
        idle(TOTAL_LATENCY + 2);
        check_value("rgb_valid count", pixels_in, pixels_out);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
        end
        $display("test %s: %s (%0d errors)", test_name, (errors == test_err0) ? "ok" : "fail",
                 errors - test_err0);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        int dx[4];
        int dy[4];
        dx = '{5, -40, 5, 40};
        dy = '{40, 5, -40, 5};
        rst_in = 1'b1;
        valid_in = 1'b0;
        ray_x = '0;
        ray_y = '0;
        ray_z = '0;
        t_in = '0;
        eye_x = '0;
        eye_y = '0;
        eye_z = '0;
        block_x = '0;
        block_y = '0;
        block_z = '0;
        block_dir = UP;
        block_color = BLUE;
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        start_test("reset quiet");
        check_value("rgb_valid", 0, int'(rgb_valid));
        idle(20);
        finish_test();

        start_test("strobe timing");
        send_hit(5, 40, 100, UP, RED);
        send_hit(0, 0, 100, UP, BLUE);
        send_hit(120, 0, 100, LEFT, RED);
        send_hit(5, -40, 100, DOWN, BLUE);
        idle(3);
        send_hit(-40, 5, 100, RIGHT, RED);
        idle(1);
        send_hit(40, 5, 100, LEFT, BLUE);
        send_hit(40, 5, 100, UP, RED);
        finish_test();

        start_test("material colours");
        send_hit(120, 0, 100, UP, RED);
        send_hit(120, 0, 100, UP, BLUE);
        send_hit(0, -90, 100, DOWN, RED);
        send_hit(5, 40, 100, DOWN, RED);
        send_hit(5, 40, 100, DOWN, BLUE);
        finish_test();

        start_test("arrow directions");
        for (int d = 0; d < 4; d++) begin
            send_hit(dx[d], dy[d], 100, arrow_dir_e'(d), RED);
            for (int o = 0; o < 4; o++) begin
                if (o != d) begin
                    send_hit(dx[d], dy[d], 100, arrow_dir_e'(o), block_color_e'(o % 2));
                end
            end
        end
        finish_test();

        start_test("depth limit");
        for (int d = 0; d < 4; d++) begin
            send_hit(dx[d], dy[d], 200, arrow_dir_e'(d), BLUE);
            send_hit(dx[d], dy[d], 201, arrow_dir_e'(d), RED);
            send_hit(dx[d], dy[d], 260, arrow_dir_e'(d), BLUE);
        end
        finish_test();

        start_test("random pixels");
        for (int i = 0; i < 300; i++) begin
            send_random();
            if (rand_range(0, 3) == 0) begin
                idle(rand_range(1, 3));
            end
        end
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/shade_pkg.sv
logic/delay_line.sv
logic/ray_scale.sv
logic/arrow_test.sv
logic/pixel_color_out.sv
logic/pixel_shade_top.sv
verification/pixel_shade_chk.sv
verification/pixel_shade_tb.sv

//--- Makefile
# Verilator simulation of the pixel shade pipeline

BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module pixel_shade_tb -Mdir $(BUILD)
	./$(BUILD)/Vpixel_shade_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
